/* design/controlPkg.sv */
// instruction field codes, state and class enums, control select types and codes
`default_nettype none

package controlPkg;

    typedef logic [5:0] opcodeT;
    typedef logic [5:0] functT;
    typedef logic [2:0] aluOpT;
    typedef logic [1:0] muxSel2T;
    typedef logic [2:0] pcSourceT;
    typedef logic [3:0] dataSourceT;

    localparam opcodeT opRType = 6'h00;
    localparam opcodeT opJ     = 6'h02;
    localparam opcodeT opJal   = 6'h03;
    localparam opcodeT opBeq   = 6'h04;
    localparam opcodeT opBne   = 6'h05;
    localparam opcodeT opAddi  = 6'h08;
    localparam opcodeT opAddiu = 6'h09;
    localparam opcodeT opLw    = 6'h23;
    localparam opcodeT opSw    = 6'h2B;

    localparam functT fAdd = 6'h20;
    localparam functT fSub = 6'h22;
    localparam functT fAnd = 6'h24;

    typedef enum logic [3:0] {
        clsAdd, clsSub, clsAnd, clsAddi, clsAddiu,
        clsBeq, clsBne, clsLw, clsSw, clsJ, clsJal,
        clsIllegal
    } instrClassT;

    typedef enum logic [3:0] {
        stFetch, stFetchWait, stIrLoad, stDecode,
        stAluExec, stAluWrite,
        stBranch, stJump, stJalLink,
        stLoadAddr, stLoadWait, stLoadWrite,
        stStoreAddr, stStoreWrite,
        stException
    } ctrlStateT;

    localparam aluOpT aluAdd = 3'b001;
    localparam aluOpT aluSub = 3'b010;
    localparam aluOpT aluAnd = 3'b011;

    localparam pcSourceT pcAluResult    = 3'd0; // straight from the alu
    localparam pcSourceT pcAluOut       = 3'd1; // branch target held in aluOut
    localparam pcSourceT pcJumpTarget   = 3'd2;
    localparam pcSourceT pcExceptVector = 3'd3;

    localparam dataSourceT dsAluOut  = 4'd0;
    localparam dataSourceT dsMemData = 4'd1;
    localparam dataSourceT dsPc      = 4'd2; // return address for jal

    localparam muxSel2T iorPc     = 2'd0;
    localparam muxSel2T iorAluOut = 2'd1;

    localparam muxSel2T srcAPc  = 2'd0;
    localparam muxSel2T srcAReg = 2'd1;

    localparam muxSel2T srcBReg    = 2'd0;
    localparam muxSel2T srcBFour   = 2'd1;
    localparam muxSel2T srcBImm    = 2'd2;
    localparam muxSel2T srcBBranch = 2'd3; // sign extended offset << 2

    localparam muxSel2T regRt = 2'd0;
    localparam muxSel2T regRd = 2'd1;
    localparam muxSel2T regRa = 2'd3; // r31

    localparam muxSel2T excNoOpcode = 2'd0;
    localparam muxSel2T excOverflow = 2'd1;

endpackage

`default_nettype wire

/* design/instrDecoder.sv */
// decoder from opcode and funct to instruction class
`timescale 1ns/100ps
`default_nettype none

module instrDecoder (
    input  wire controlPkg::opcodeT opcode,
    input  wire controlPkg::functT  funct,
    output controlPkg::instrClassT  instrClass
);

    controlPkg::instrClassT rClass;

    // R-type is split on funct
    always_comb begin
        case (funct)
            controlPkg::fAdd: rClass = controlPkg::clsAdd;
            controlPkg::fSub: rClass = controlPkg::clsSub;
            controlPkg::fAnd: rClass = controlPkg::clsAnd;
            default:          rClass = controlPkg::clsIllegal; // unsupported funct
        endcase
    end

    always_comb begin
        case (opcode)
            controlPkg::opRType: begin
                instrClass = rClass;
            end
            controlPkg::opAddi: begin
                instrClass = controlPkg::clsAddi;
            end
            controlPkg::opAddiu: begin
                instrClass = controlPkg::clsAddiu;
            end
            controlPkg::opBeq: begin
                instrClass = controlPkg::clsBeq;
            end
            controlPkg::opBne: begin
                instrClass = controlPkg::clsBne;
            end
            controlPkg::opLw: begin
                instrClass = controlPkg::clsLw;
            end
            controlPkg::opSw: begin
                instrClass = controlPkg::clsSw;
            end
            controlPkg::opJ: begin
                instrClass = controlPkg::clsJ;
            end
            controlPkg::opJal: begin
                instrClass = controlPkg::clsJal;
            end
            default: begin
                instrClass = controlPkg::clsIllegal; // nonexistent opcode
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/controlSequencer.sv */
// state register, class latch, memory wait counter and next-state logic of the control FSM
`timescale 1ns/100ps
`default_nettype none

module controlSequencer #(
    parameter int memWaitCycles = 1
) (
    input  wire clk,
    input  wire reset,
    input  wire controlPkg::instrClassT instrClass,
    input  wire overflow,
    output controlPkg::ctrlStateT state,
    output controlPkg::instrClassT curClass
);

    localparam int cntW = (memWaitCycles > 1) ? $clog2(memWaitCycles) : 1;
    localparam logic [cntW-1:0] lastCnt = cntW'(memWaitCycles - 1);

    controlPkg::ctrlStateT nextState;
    controlPkg::ctrlStateT dispatchState;
    logic [cntW-1:0] waitCnt;
    logic inWait;
    logic waitDone;
    logic trapOverflow;

    assign inWait   = (state == controlPkg::stFetchWait) || (state == controlPkg::stLoadWait);
    assign waitDone = (waitCnt == lastCnt);

    // only the signed ALU classes trap
    assign trapOverflow = overflow && ((curClass == controlPkg::clsAdd) ||
                                       (curClass == controlPkg::clsSub) ||
                                       (curClass == controlPkg::clsAddi));

    // shared by fetch and load waits
    always_ff @(posedge clk) begin
        if (reset) begin
            waitCnt <= '0;
        end else if (inWait && !waitDone) begin
            waitCnt <= waitCnt + 1'b1;
        end else begin
            waitCnt <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= controlPkg::stFetch;
            curClass <= controlPkg::clsIllegal;
        end else begin
            state <= nextState;
            if (state == controlPkg::stDecode) begin
                curClass <= instrClass; // held for the whole execute path
            end
        end
    end

    always_comb begin
        case (instrClass)
            controlPkg::clsAdd,
            controlPkg::clsSub,
            controlPkg::clsAnd,
            controlPkg::clsAddi,
            controlPkg::clsAddiu: dispatchState = controlPkg::stAluExec;
            controlPkg::clsBeq,
            controlPkg::clsBne:   dispatchState = controlPkg::stBranch;
            controlPkg::clsLw:    dispatchState = controlPkg::stLoadAddr;
            controlPkg::clsSw:    dispatchState = controlPkg::stStoreAddr;
            controlPkg::clsJ:     dispatchState = controlPkg::stJump;
            controlPkg::clsJal:   dispatchState = controlPkg::stJalLink;
            default:              dispatchState = controlPkg::stException;
        endcase
    end

    always_comb begin
        nextState = state;
        case (state)
            controlPkg::stFetch: begin
                nextState = controlPkg::stFetchWait;
            end
            controlPkg::stFetchWait: begin
                if (waitDone) begin
                    nextState = controlPkg::stIrLoad;
                end
            end
            controlPkg::stIrLoad: begin
                nextState = controlPkg::stDecode;
            end
            controlPkg::stDecode: begin
                nextState = dispatchState;
            end
            controlPkg::stAluExec: begin
                nextState = trapOverflow ? controlPkg::stException : controlPkg::stAluWrite;
            end
            controlPkg::stJalLink: begin
                nextState = controlPkg::stJump; // link first, then jump
            end
            controlPkg::stLoadAddr: begin
                nextState = controlPkg::stLoadWait;
            end
            controlPkg::stLoadWait: begin
                if (waitDone) begin
                    nextState = controlPkg::stLoadWrite;
                end
            end
            controlPkg::stStoreAddr: begin
                nextState = controlPkg::stStoreWrite;
            end
            default: begin
                nextState = controlPkg::stFetch; // last cycle of every execute path
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/controlOutputs.sv */
// registered control word from state and latched class
`timescale 1ns/100ps
`default_nettype none

module controlOutputs (
    input  wire clk,
    input  wire reset,
    input  wire controlPkg::ctrlStateT  state,
    input  wire controlPkg::instrClassT curClass,
    input  wire equals,
    output logic pcWrite,
    output controlPkg::pcSourceT pcSource,
    output controlPkg::muxSel2T iorD,
    output logic memWrite,
    output logic irWrite,
    output logic regWrite,
    output controlPkg::muxSel2T regDest,
    output controlPkg::dataSourceT dataSource,
    output controlPkg::muxSel2T aluSrcA,
    output controlPkg::muxSel2T aluSrcB,
    output controlPkg::aluOpT aluControl,
    output logic aWrite,
    output logic bWrite,
    output logic aluOutWrite,
    output logic epcWrite,
    output controlPkg::muxSel2T excptControl
);

    controlPkg::aluOpT classAluOp;
    controlPkg::muxSel2T classRegDest;
    controlPkg::muxSel2T classSrcB;
    logic isRType;
    logic trapsOverflow;
    logic branchTaken;

    assign isRType = (curClass == controlPkg::clsAdd) || (curClass == controlPkg::clsSub) ||
                     (curClass == controlPkg::clsAnd);
    assign trapsOverflow = (curClass == controlPkg::clsAdd) || (curClass == controlPkg::clsSub) ||
                           (curClass == controlPkg::clsAddi);
    assign branchTaken = ((curClass == controlPkg::clsBeq) && equals) ||
                         ((curClass == controlPkg::clsBne) && !equals);

    assign classRegDest = isRType ? controlPkg::regRd : controlPkg::regRt;
    assign classSrcB    = isRType ? controlPkg::srcBReg : controlPkg::srcBImm;

    always_comb begin
        case (curClass)
            controlPkg::clsSub: classAluOp = controlPkg::aluSub;
            controlPkg::clsAnd: classAluOp = controlPkg::aluAnd;
            default:            classAluOp = controlPkg::aluAdd; // add, addi, addiu
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pcWrite      <= 1'b0;
            pcSource     <= controlPkg::pcAluResult;
            iorD         <= controlPkg::iorPc;
            memWrite     <= 1'b0;
            irWrite      <= 1'b0;
            regWrite     <= 1'b0;
            regDest      <= controlPkg::regRa;
            dataSource   <= controlPkg::dsAluOut;
            aluSrcA      <= controlPkg::srcAPc;
            aluSrcB      <= controlPkg::srcBReg;
            aluControl   <= controlPkg::aluAdd;
            aWrite       <= 1'b0;
            bWrite       <= 1'b0;
            aluOutWrite  <= 1'b0;
            epcWrite     <= 1'b0;
            excptControl <= controlPkg::excNoOpcode;
        end else begin
            pcWrite      <= 1'b0;
            pcSource     <= controlPkg::pcAluResult;
            iorD         <= controlPkg::iorPc;
            memWrite     <= 1'b0;
            irWrite      <= 1'b0;
            regWrite     <= 1'b0;
            regDest      <= classRegDest;
            dataSource   <= controlPkg::dsAluOut;
            aluSrcA      <= controlPkg::srcAPc;
            aluSrcB      <= controlPkg::srcBReg;
            aluControl   <= controlPkg::aluAdd;
            aWrite       <= 1'b0;
            bWrite       <= 1'b0;
            aluOutWrite  <= 1'b0;
            epcWrite     <= 1'b0;
            excptControl <= controlPkg::excNoOpcode;
            case (state)
                controlPkg::stFetch: begin
                    pcWrite <= 1'b1; // pc + 4
                    aluSrcB <= controlPkg::srcBFour;
                end
                controlPkg::stIrLoad: begin
                    irWrite <= 1'b1;
                end
                controlPkg::stDecode: begin
                    aWrite      <= 1'b1;
                    bWrite      <= 1'b1;
                    aluOutWrite <= 1'b1; // branch target kept for stBranch
                    aluSrcB     <= controlPkg::srcBBranch;
                end
                controlPkg::stAluExec: begin
                    aluSrcA     <= controlPkg::srcAReg;
                    aluSrcB     <= classSrcB;
                    aluControl  <= classAluOp;
                    aluOutWrite <= 1'b1;
                end
                controlPkg::stAluWrite: begin
                    regWrite   <= 1'b1;
                    aluSrcA    <= controlPkg::srcAReg;
                    aluSrcB    <= classSrcB;
                    aluControl <= classAluOp;
                end
                controlPkg::stBranch: begin
                    pcWrite    <= branchTaken;
                    pcSource   <= controlPkg::pcAluOut;
                    aluSrcA    <= controlPkg::srcAReg;
                    aluControl <= controlPkg::aluSub; // compare rs and rt
                end
                controlPkg::stJump: begin
                    pcWrite  <= 1'b1;
                    pcSource <= controlPkg::pcJumpTarget;
                end
                controlPkg::stJalLink: begin
                    regWrite   <= 1'b1;
                    regDest    <= controlPkg::regRa;
                    dataSource <= controlPkg::dsPc;
                end
                controlPkg::stLoadAddr, controlPkg::stStoreAddr: begin
                    aluSrcA     <= controlPkg::srcAReg;
                    aluSrcB     <= controlPkg::srcBImm;
                    aluOutWrite <= 1'b1; // effective address
                end
                controlPkg::stLoadWait: begin
                    iorD <= controlPkg::iorAluOut;
                end
                controlPkg::stLoadWrite: begin
                    iorD       <= controlPkg::iorAluOut;
                    regWrite   <= 1'b1;
                    regDest    <= controlPkg::regRt;
                    dataSource <= controlPkg::dsMemData;
                end
                controlPkg::stStoreWrite: begin
                    iorD     <= controlPkg::iorAluOut;
                    memWrite <= 1'b1;
                end
                controlPkg::stException: begin
                    epcWrite     <= 1'b1;
                    pcWrite      <= 1'b1;
                    pcSource     <= controlPkg::pcExceptVector;
                    excptControl <= trapsOverflow ? controlPkg::excOverflow
                                                  : controlPkg::excNoOpcode;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/controlUnit.sv */
// multicycle control top with decoder, sequencer and output register
`timescale 1ns/100ps
`default_nettype none

module controlUnit #(
    parameter int memWaitCycles = 1
) (
    input  wire clk,
    input  wire reset,
    input  wire controlPkg::opcodeT opcode,
    input  wire controlPkg::functT  funct,
    input  wire equals,
    input  wire overflow,
    output wire pcWrite,
    output wire controlPkg::pcSourceT pcSource,
    output wire controlPkg::muxSel2T iorD,
    output wire memWrite,
    output wire irWrite,
    output wire regWrite,
    output wire controlPkg::muxSel2T regDest,
    output wire controlPkg::dataSourceT dataSource,
    output wire controlPkg::muxSel2T aluSrcA,
    output wire controlPkg::muxSel2T aluSrcB,
    output wire controlPkg::aluOpT aluControl,
    output wire aWrite,
    output wire bWrite,
    output wire aluOutWrite,
    output wire epcWrite,
    output wire controlPkg::muxSel2T excptControl
);

    controlPkg::instrClassT instrClass;
    controlPkg::instrClassT curClass;
    controlPkg::ctrlStateT  state;

    instrDecoder decoder (
        .opcode     (opcode),
        .funct      (funct),
        .instrClass (instrClass)
    );

    controlSequencer #(
        .memWaitCycles (memWaitCycles)
    ) sequencer (
        .clk        (clk),
        .reset      (reset),
        .instrClass (instrClass),
        .overflow   (overflow),
        .state      (state),
        .curClass   (curClass)
    );

    controlOutputs outputs (
        .clk          (clk),
        .reset        (reset),
        .state        (state),
        .curClass     (curClass),
        .equals       (equals),
        .pcWrite      (pcWrite),
        .pcSource     (pcSource),
        .iorD         (iorD),
        .memWrite     (memWrite),
        .irWrite      (irWrite),
        .regWrite     (regWrite),
        .regDest      (regDest),
        .dataSource   (dataSource),
        .aluSrcA      (aluSrcA),
        .aluSrcB      (aluSrcB),
        .aluControl   (aluControl),
        .aWrite       (aWrite),
        .bWrite       (bWrite),
        .aluOutWrite  (aluOutWrite),
        .epcWrite     (epcWrite),
        .excptControl (excptControl)
    );

endmodule

`default_nettype wire

/* tb/tbClockGen.sv */
// clock and reset generator for the testbench
`timescale 1ns/100ps
`default_nettype none

module tbClockGen #(
    parameter int periodNs    = 20,
    parameter int resetCycles = 8
) (
    output logic clk,
    output logic reset
);

    always #(periodNs / 2) clk = ~clk;

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0; // released on a rising edge
    end

endmodule

`default_nettype wire

/* tb/controlUnit_asserts.sv */
// concurrent checks on the control unit outputs and their bind into controlUnit
`timescale 1ns/100ps
`default_nettype none

module controlUnit_asserts #(
    parameter int memWaitCycles = 1
) (
    input wire clk,
    input wire reset,
    input wire controlPkg::opcodeT opcode,
    input wire controlPkg::functT funct,
    input wire equals,
    input wire overflow,
    input wire pcWrite,
    input wire controlPkg::pcSourceT pcSource,
    input wire controlPkg::muxSel2T iorD,
    input wire memWrite,
    input wire irWrite,
    input wire regWrite,
    input wire controlPkg::muxSel2T regDest,
    input wire controlPkg::dataSourceT dataSource,
    input wire controlPkg::muxSel2T aluSrcA,
    input wire controlPkg::muxSel2T aluSrcB,
    input wire controlPkg::aluOpT aluControl,
    input wire aWrite,
    input wire bWrite,
    input wire aluOutWrite,
    input wire epcWrite,
    input wire controlPkg::muxSel2T excptControl
);

    int failCount = 0;
    wire anyWrite = pcWrite | irWrite | regWrite | memWrite | epcWrite |
                    aWrite | bWrite | aluOutWrite;

    function automatic logic isRAlu(controlPkg::opcodeT op, controlPkg::functT fn);
        return (op == controlPkg::opRType) &&
               (fn == controlPkg::fAdd || fn == controlPkg::fSub || fn == controlPkg::fAnd);
    endfunction

    function automatic logic isAluInstr(controlPkg::opcodeT op, controlPkg::functT fn);
        return isRAlu(op, fn) || (op == controlPkg::opAddi) || (op == controlPkg::opAddiu);
    endfunction

    // addiu and and never trap
    function automatic logic trapsOnOverflow(controlPkg::opcodeT op, controlPkg::functT fn);
        return (op == controlPkg::opAddi) ||
               ((op == controlPkg::opRType) && (fn == controlPkg::fAdd || fn == controlPkg::fSub));
    endfunction

    function automatic controlPkg::aluOpT aluFor(controlPkg::opcodeT op, controlPkg::functT fn);
        if (op == controlPkg::opRType && fn == controlPkg::fSub) return controlPkg::aluSub;
        if (op == controlPkg::opRType && fn == controlPkg::fAnd) return controlPkg::aluAnd;
        return controlPkg::aluAdd;
    endfunction

    function automatic logic isIllegal(controlPkg::opcodeT op, controlPkg::functT fn);
        case (op)
            controlPkg::opRType: return !isRAlu(op, fn);
            controlPkg::opJ, controlPkg::opJal, controlPkg::opBeq, controlPkg::opBne,
            controlPkg::opAddi, controlPkg::opAddiu, controlPkg::opLw,
            controlPkg::opSw: return 1'b0;
            default: return 1'b1;
        endcase
    endfunction

    resetQuiet: assert property (@(posedge clk)
        $fell(reset) |-> !anyWrite ##1 (pcWrite && !irWrite && !regWrite && !memWrite && !epcWrite))
        else begin failCount++; $error("Fail %0t: write enable high after reset", $time); end

    // pc + 4 at fetch, irWrite after the wait, then the decode word
    fetchToIr: assert property (@(posedge clk) disable iff (reset)
        pcWrite && pcSource == controlPkg::pcAluResult |->
            (aluSrcA == controlPkg::srcAPc && aluSrcB == controlPkg::srcBFour &&
             aluControl == controlPkg::aluAdd && iorD == controlPkg::iorPc)
            ##1 !irWrite [*memWaitCycles] ##1 irWrite
            ##1 (aWrite && bWrite && aluOutWrite && aluSrcB == controlPkg::srcBBranch))
        else begin failCount++; $error("Fail %0t: fetch or decode control word wrong", $time); end

    aluWrite: assert property (@(posedge clk) disable iff (reset)
        irWrite && isAluInstr(opcode, funct) && !(overflow && trapsOnOverflow(opcode, funct)) |->
            !regWrite ##1 !regWrite ##1 (!regWrite && aluControl == aluFor(opcode, funct) &&
                                         aluSrcA == controlPkg::srcAReg &&
                                         aluSrcB == (isRAlu(opcode, funct) ? controlPkg::srcBReg
                                                                           : controlPkg::srcBImm))
            ##1 (regWrite && dataSource == controlPkg::dsAluOut &&
                 regDest == (isRAlu(opcode, funct) ? controlPkg::regRd : controlPkg::regRt) &&
                 aluControl == aluFor(opcode, funct))
            ##1 !regWrite)
        else begin failCount++; $error("Fail %0t: wrong ALU register write", $time); end

    branchRule: assert property (@(posedge clk) disable iff (reset)
        irWrite && (opcode == controlPkg::opBeq || opcode == controlPkg::opBne) |->
            ##2 (pcSource == controlPkg::pcAluOut && pcWrite ==
                 ((opcode == controlPkg::opBeq && equals) ||
                  (opcode == controlPkg::opBne && !equals))))
        else begin failCount++; $error("Fail %0t: branch pcWrite wrong", $time); end

    illegalTrap: assert property (@(posedge clk) disable iff (reset)
        irWrite && isIllegal(opcode, funct) |->
            ##1 (!regWrite && !memWrite)
            ##1 (epcWrite && pcWrite && pcSource == controlPkg::pcExceptVector &&
                 excptControl == controlPkg::excNoOpcode && !regWrite && !memWrite)
            ##1 !epcWrite)
        else begin failCount++; $error("Fail %0t: no-opcode exception wrong", $time); end

    overflowTrap: assert property (@(posedge clk) disable iff (reset)
        irWrite && isAluInstr(opcode, funct) && trapsOnOverflow(opcode, funct) && overflow |->
            !regWrite [*3] ##1 (epcWrite && pcWrite && !regWrite &&
                                pcSource == controlPkg::pcExceptVector &&
                                excptControl == controlPkg::excOverflow))
        else begin failCount++; $error("Fail %0t: overflow exception wrong", $time); end

    loadWrite: assert property (@(posedge clk) disable iff (reset)
        irWrite && opcode == controlPkg::opLw |->
            !regWrite [*(memWaitCycles + 3)] ##1 (regWrite && regDest == controlPkg::regRt &&
                                                   dataSource == controlPkg::dsMemData &&
                                                   iorD == controlPkg::iorAluOut))
        else begin failCount++; $error("Fail %0t: lw register write wrong", $time); end

    storeWrite: assert property (@(posedge clk) disable iff (reset)
        irWrite && opcode == controlPkg::opSw |->
            !memWrite [*3] ##1 (memWrite && iorD == controlPkg::iorAluOut) ##1 !memWrite)
        else begin failCount++; $error("Fail %0t: sw memWrite pulse wrong", $time); end

    jalLink: assert property (@(posedge clk) disable iff (reset)
        irWrite && opcode == controlPkg::opJal |->
            ##2 (regWrite && regDest == controlPkg::regRa && dataSource == controlPkg::dsPc)
            ##1 (pcWrite && pcSource == controlPkg::pcJumpTarget && !regWrite))
        else begin failCount++; $error("Fail %0t: jal link or jump wrong", $time); end

endmodule

bind controlUnit controlUnit_asserts #(.memWaitCycles(memWaitCycles)) checks (.*);

`default_nettype wire

/* tb/controlUnitTb.sv */
// testbench top with random instruction stream, timeout and final report
`timescale 1ns/100ps
`default_nettype none

module controlUnitTb;

    localparam int waitCycles     = 1; // DUT default memWaitCycles
    localparam int resetCycles    = 8;
    localparam int numInstr       = 40;
    localparam int maxInstrCycles = 5 + 2 * waitCycles; // lw, fetch included
    localparam int timeoutCycles  = numInstr * maxInstrCycles + resetCycles + 20;

    logic clk;
    logic reset;
    controlPkg::opcodeT opcode;
    controlPkg::functT funct;
    logic equals;
    logic overflow;
    wire pcWrite;
    wire controlPkg::pcSourceT pcSource;
    wire controlPkg::muxSel2T iorD;
    wire memWrite;
    wire irWrite;
    wire regWrite;
    wire controlPkg::muxSel2T regDest;
    wire controlPkg::dataSourceT dataSource;
    wire controlPkg::muxSel2T aluSrcA;
    wire controlPkg::muxSel2T aluSrcB;
    wire controlPkg::aluOpT aluControl;
    wire aWrite;
    wire bWrite;
    wire aluOutWrite;
    wire epcWrite;
    wire controlPkg::muxSel2T excptControl;

    int seed;
    int cycleCount;
    int fetchCount;

    tbClockGen #(.periodNs(20), .resetCycles(resetCycles)) clockGen (
        .clk   (clk),
        .reset (reset)
    );

    controlUnit dut (.*);

    // weighted list with the last three entries illegal
    function automatic logic [11:0] instrFor(int pick);
        case (pick)
            0, 1:    return {controlPkg::opRType, controlPkg::fAdd};
            2:       return {controlPkg::opRType, controlPkg::fSub};
            3:       return {controlPkg::opRType, controlPkg::fAnd};
            4, 5:    return {controlPkg::opAddi, 6'h3F};
            6:       return {controlPkg::opAddiu, 6'h3F};
            7:       return {controlPkg::opBeq, 6'h3F};
            8:       return {controlPkg::opBne, 6'h3F};
            9:       return {controlPkg::opLw, 6'h3F};
            10:      return {controlPkg::opSw, 6'h3F};
            11:      return {controlPkg::opJ, 6'h3F};
            12:      return {controlPkg::opJal, 6'h3F};
            13:      return {controlPkg::opRType, 6'h00}; // sll, dropped
            14:      return {6'h0C, 6'h3F};
            default: return {6'h3F, 6'h3F};
        endcase
    endfunction

    task automatic issueNext();
        int pick;
        int flip;
        pick = {$random(seed)} % 16;
        {opcode, funct} <= instrFor(pick);
        flip = $random(seed);
        equals <= flip[0];
        flip = $random(seed);
        overflow <= flip[0];
    endtask

    initial begin
        seed       = 35;
        opcode     = controlPkg::opJ;
        funct      = '0;
        equals     = 1'b0;
        overflow   = 1'b0;
        cycleCount = 0;
        fetchCount = 0;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("TEST FAIL");
            $fatal(1, "timeout: %0d instructions did not finish in %0d cycles",
                   numInstr, timeoutCycles);
        end else if (!reset && pcWrite && pcSource == controlPkg::pcAluResult) begin
            fetchCount <= fetchCount + 1; // next fetch has started
            issueNext();
        end
    end

    always @(dut.checks.failCount) begin
        if (dut.checks.failCount != 0) begin
            $display("TEST FAIL");
            $fatal(1, "an assertion on the control outputs failed");
        end
    end

    initial begin
        wait (fetchCount == numInstr + 1);
        repeat (3) @(posedge clk); // let the last checks finish
        if (dut.checks.failCount != 0) begin
            $display("TEST FAIL");
            $fatal(1, "an assertion on the control outputs failed");
        end else begin
            $display("%0d instructions run in %0d cycles", numInstr, cycleCount);
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* filelist.f */
design/controlPkg.sv
design/instrDecoder.sv
design/controlSequencer.sv
design/controlOutputs.sv
design/controlUnit.sv
tb/tbClockGen.sv
tb/controlUnit_asserts.sv
tb/controlUnitTb.sv
